//--- Bender.yml
package:
  name: husky_core

sources:
  - src/husky_pkg.sv
  - src/usb_reg_bus.sv
  - src/status_regs.sv
  - src/target_pin_ctrl.sv
  - src/capture_fifo.sv
  - src/husky_top.sv
  - target: test
    include_dirs:
      - verif
    files:
      - verif/tb_husky_top.sv

//--- sources.f
+incdir+verif
src/husky_pkg.sv
src/usb_reg_bus.sv
src/status_regs.sv
src/target_pin_ctrl.sv
src/capture_fifo.sv
src/husky_top.sv
verif/tb_husky_top.sv

//--- src/capture_fifo.sv
`timescale 1ns/1ps

module capture_fifo #(
   parameter int pFIFO_DEPTH = 16
) (
   input  logic                         clk_usb_buf,
   input  logic                         rst_n_i,
   input  husky_pkg::reg_bus_t          bus_i,
   input  husky_pkg::sample_src_t       trace_src_i,
   input  husky_pkg::sample_src_t       la_src_i,
   output logic [husky_pkg::BYTE_W-1:0] rdata_o,
   output logic                         fifo_empty_o,
   output logic                         overflow_o,
   output logic                         underflow_o
);
   import husky_pkg::*;

   localparam int PTR_W = $clog2(pFIFO_DEPTH);

   logic [BYTE_W-1:0] mem [pFIFO_DEPTH];
   logic [PTR_W:0]    wptr_q;          // extra bit tells full from empty
   logic [PTR_W:0]    rptr_q;
   logic [PTR_W:0]    count;
   logic              src_sel_q;       // 0 trace, 1 LA
   sample_src_t       src;
   logic              full;
   logic              empty;
   logic              push;
   logic              pop;
   logic              flush;
   logic [BYTE_W-1:0] head;

   assign src   = src_sel_q ? la_src_i : trace_src_i;
   assign count = wptr_q - rptr_q;
   assign empty = (count == '0);
   assign full  = (count == pFIFO_DEPTH[PTR_W:0]);
   assign flush = bus_i.wr && bus_i.addr == FIFO_CTRL_ADDR && bus_i.wdata[1];
   assign push  = src.wr && !full;
   assign pop   = bus_i.rd && bus_i.addr == FIFO_DATA_ADDR && !empty;

   always_ff @(posedge clk_usb_buf or negedge rst_n_i) begin
      if (!rst_n_i) begin
         wptr_q    <= '0;
         rptr_q    <= '0;
         src_sel_q <= 1'b0;
      end else begin
         if (bus_i.wr && bus_i.addr == FIFO_CTRL_ADDR)
            src_sel_q <= bus_i.wdata[0];
         if (flush) begin
            wptr_q <= '0;
            rptr_q <= '0;
         end else begin
            if (push)
               wptr_q <= wptr_q + 1'b1;
            if (pop)
               rptr_q <= rptr_q + 1'b1;
         end
      end
   end

   always_ff @(posedge clk_usb_buf) begin
      if (push)
         mem[wptr_q[PTR_W-1:0]] <= src.data;
   end

   assign head = empty ? '0 : mem[rptr_q[PTR_W-1:0]];   // empty read gives 0

   assign overflow_o   = src.wr && full;            // sample dropped
   assign underflow_o  = bus_i.rd && bus_i.addr == FIFO_DATA_ADDR && empty;
   assign fifo_empty_o = empty;

   always_comb begin
      case (bus_i.addr)
         FIFO_CTRL_ADDR:   rdata_o = {7'b0000000, src_sel_q};  // flush bit reads 0
         FIFO_STATUS_ADDR: rdata_o = {empty, full, 6'(count)};
         FIFO_DATA_ADDR:   rdata_o = head;
         default:          rdata_o = '0;
      endcase
   end

endmodule

//--- src/husky_pkg.sv
package husky_pkg;

   localparam int BYTE_W = 8;               // register data width
   localparam int ADDR_W = 8;               // register address width

   // one decoded access on the internal register bus
   typedef struct packed {
      logic [ADDR_W-1:0] addr;
      logic [BYTE_W-1:0] wdata;
      logic              rd;                // one-cycle read pulse
      logic              wr;                // one-cycle write pulse
   } reg_bus_t;

   localparam int NUM_RD_SRC = 3;           // target, status, fifo

   typedef logic [NUM_RD_SRC-1:0][BYTE_W-1:0] rdata_vec_t;

   // register map
   localparam logic [ADDR_W-1:0] TARGET_CTRL_ADDR = 8'h10;
   localparam logic [ADDR_W-1:0] STATUS_ADDR      = 8'h11;
   localparam logic [ADDR_W-1:0] FIFO_CTRL_ADDR   = 8'h12;
   localparam logic [ADDR_W-1:0] FIFO_STATUS_ADDR = 8'h13;
   localparam logic [ADDR_W-1:0] FIFO_DATA_ADDR   = 8'h14;

   // target pin drive, split value and enable
   typedef struct packed {
      logic nrst_val;
      logic nrst_oe;
      logic pdid_val;
      logic pdid_oe;
      logic mosi_val;
      logic mosi_oe;
      logic sck_val;
      logic sck_oe;
   } target_pins_t;

   // sample stream from a capture source
   typedef struct packed {
      logic              wr;
      logic [BYTE_W-1:0] data;
   } sample_src_t;

   // error flag positions in STATUS
   localparam int ERR_OVERFLOW_BIT  = 0;
   localparam int ERR_UNDERFLOW_BIT = 1;

endpackage

//--- src/husky_top.sv
`timescale 1ns/1ps

module husky_top #(
   parameter int pFIFO_DEPTH = 16,
   parameter int pFLASH_BITS = 4
) (
   input  logic                         clk_usb_buf,
   input  logic                         rst_n_i,
   input  logic [husky_pkg::ADDR_W-1:0] usb_addr_i,
   input  logic [husky_pkg::BYTE_W-1:0] usb_data_i,
   input  logic                         usb_rd_n_i,
   input  logic                         usb_wr_n_i,
   input  logic                         usb_ce_n_i,
   input  logic                         usb_ale_n_i,
   output logic [husky_pkg::BYTE_W-1:0] usb_data_o,
   output logic                         usb_data_oe_o,
   input  logic                         pll_status_i,
   output logic                         led_adc_o,
   output logic                         led_fifo_o,
   input  logic                         sam_mosi_i,
   input  logic                         sam_spck_i,
   input  logic                         avr_nrst_i,
   input  logic                         target_miso_i,
   output husky_pkg::target_pins_t      pins_o,
   output logic                         target_power_on_o,
   output logic                         sam_miso_o,
   output logic                         sam_miso_oe_o,
   input  husky_pkg::sample_src_t       trace_src_i,
   input  husky_pkg::sample_src_t       la_src_i
);
   import husky_pkg::*;

   reg_bus_t   bus;
   rdata_vec_t src_rdata;           // [0] target, [1] status, [2] fifo
   logic       overflow;
   logic       underflow;
   logic       fifo_empty;

   usb_reg_bus usb_reg_bus_inst (
      .clk_usb_buf   (clk_usb_buf),
      .rst_n_i       (rst_n_i),
      .usb_addr_i    (usb_addr_i),
      .usb_data_i    (usb_data_i),
      .usb_rd_n_i    (usb_rd_n_i),
      .usb_wr_n_i    (usb_wr_n_i),
      .usb_ce_n_i    (usb_ce_n_i),
      .usb_ale_n_i   (usb_ale_n_i),
      .src_rdata_i   (src_rdata),
      .usb_data_o    (usb_data_o),
      .usb_data_oe_o (usb_data_oe_o),
      .bus_o         (bus)
   );

   target_pin_ctrl target_pin_ctrl_inst (
      .clk_usb_buf       (clk_usb_buf),
      .rst_n_i           (rst_n_i),
      .bus_i             (bus),
      .sam_mosi_i        (sam_mosi_i),
      .sam_spck_i        (sam_spck_i),
      .avr_nrst_i        (avr_nrst_i),
      .target_miso_i     (target_miso_i),
      .rdata_o           (src_rdata[0]),
      .pins_o            (pins_o),
      .target_power_on_o (target_power_on_o),
      .sam_miso_o        (sam_miso_o),
      .sam_miso_oe_o     (sam_miso_oe_o)
   );

   status_regs #(
      .pFLASH_BITS (pFLASH_BITS)
   ) status_regs_inst (
      .clk_usb_buf  (clk_usb_buf),
      .rst_n_i      (rst_n_i),
      .bus_i        (bus),
      .overflow_i   (overflow),
      .underflow_i  (underflow),
      .fifo_empty_i (fifo_empty),
      .pll_status_i (pll_status_i),
      .rdata_o      (src_rdata[1]),
      .led_adc_o    (led_adc_o),
      .led_fifo_o   (led_fifo_o)
   );

   capture_fifo #(
      .pFIFO_DEPTH (pFIFO_DEPTH)
   ) capture_fifo_inst (
      .clk_usb_buf  (clk_usb_buf),
      .rst_n_i      (rst_n_i),
      .bus_i        (bus),
      .trace_src_i  (trace_src_i),
      .la_src_i     (la_src_i),
      .rdata_o      (src_rdata[2]),
      .fifo_empty_o (fifo_empty),
      .overflow_o   (overflow),
      .underflow_o  (underflow)
   );

endmodule

//--- src/status_regs.sv
`timescale 1ns/1ps

module status_regs #(
   parameter int pFLASH_BITS = 4
) (
   input  logic                         clk_usb_buf,
   input  logic                         rst_n_i,
   input  husky_pkg::reg_bus_t          bus_i,
   input  logic                         overflow_i,
   input  logic                         underflow_i,
   input  logic                         fifo_empty_i,
   input  logic                         pll_status_i,
   output logic [husky_pkg::BYTE_W-1:0] rdata_o,
   output logic                         led_adc_o,
   output logic                         led_fifo_o
);
   import husky_pkg::*;

   logic [1:0]             err_q;      // sticky error flags
   logic [1:0]             err_set;
   logic [1:0]             err_clr;
   logic [pFLASH_BITS-1:0] flash_cnt;
   logic                   err_any;
   logic                   flash;

   always_comb begin
      err_set = '0;
      err_set[ERR_OVERFLOW_BIT]  = overflow_i;
      err_set[ERR_UNDERFLOW_BIT] = underflow_i;
      err_clr = (bus_i.wr && bus_i.addr == STATUS_ADDR) ? bus_i.wdata[1:0] : 2'b00;
   end

   always_ff @(posedge clk_usb_buf or negedge rst_n_i) begin
      if (!rst_n_i) begin
         err_q     <= '0;
         flash_cnt <= '0;
      end else begin
         err_q     <= (err_q & ~err_clr) | err_set;   // a new error wins over clear
         flash_cnt <= flash_cnt + 1'b1;
      end
   end

   assign err_any = |err_q;
   assign flash   = flash_cnt[pFLASH_BITS-1];

   // fast flash on both LEDs while any error is latched
   assign led_adc_o  = err_any ? flash : ~pll_status_i;
   assign led_fifo_o = err_any ? flash : ~fifo_empty_i;

   assign rdata_o = (bus_i.addr == STATUS_ADDR) ?
                    {4'b0000, pll_status_i, fifo_empty_i, err_q} : '0;

endmodule

//--- src/target_pin_ctrl.sv
`timescale 1ns/1ps

module target_pin_ctrl (
   input  logic                         clk_usb_buf,
   input  logic                         rst_n_i,
   input  husky_pkg::reg_bus_t          bus_i,
   input  logic                         sam_mosi_i,
   input  logic                         sam_spck_i,
   input  logic                         avr_nrst_i,
   input  logic                         target_miso_i,
   output logic [husky_pkg::BYTE_W-1:0] rdata_o,
   output husky_pkg::target_pins_t      pins_o,
   output logic                         target_power_on_o,
   output logic                         sam_miso_o,
   output logic                         sam_miso_oe_o
);
   import husky_pkg::*;

   localparam int POWER_OFF_BIT = 0;
   localparam int AVRPROG_BIT   = 1;
   localparam int NRST_OE_BIT   = 2;
   localparam int NRST_VAL_BIT  = 3;
   localparam int PDID_OE_BIT   = 4;
   localparam int PDID_VAL_BIT  = 5;

   logic [5:0] ctrl_q;

   always_ff @(posedge clk_usb_buf or negedge rst_n_i) begin
      if (!rst_n_i)
         ctrl_q <= 6'b000001;                       // target starts unpowered
      else if (bus_i.wr && bus_i.addr == TARGET_CTRL_ADDR)
         ctrl_q <= bus_i.wdata[5:0];
   end

   assign target_power_on_o = ~ctrl_q[POWER_OFF_BIT];

   // high-Z on everything while the target is unpowered
   always_comb begin
      pins_o        = '0;
      sam_miso_o    = 1'b0;
      sam_miso_oe_o = 1'b0;
      if (!ctrl_q[POWER_OFF_BIT]) begin
         if (ctrl_q[AVRPROG_BIT]) begin
            pins_o.nrst_oe  = 1'b1;                 // SAM drives the ISP lines
            pins_o.nrst_val = avr_nrst_i;
            pins_o.mosi_oe  = 1'b1;
            pins_o.mosi_val = sam_mosi_i;
            pins_o.sck_oe   = 1'b1;
            pins_o.sck_val  = sam_spck_i;
            sam_miso_o      = target_miso_i;
            sam_miso_oe_o   = 1'b1;
         end else begin
            pins_o.nrst_oe  = ctrl_q[NRST_OE_BIT];
            pins_o.nrst_val = ctrl_q[NRST_VAL_BIT];
            pins_o.pdid_oe  = ctrl_q[PDID_OE_BIT];
            pins_o.pdid_val = ctrl_q[PDID_VAL_BIT];
         end
      end
   end

   assign rdata_o = (bus_i.addr == TARGET_CTRL_ADDR) ? {2'b00, ctrl_q} : '0;

endmodule

//--- src/usb_reg_bus.sv
`timescale 1ns/1ps

module usb_reg_bus (
   input  logic                         clk_usb_buf,
   input  logic                         rst_n_i,
   input  logic [husky_pkg::ADDR_W-1:0] usb_addr_i,
   input  logic [husky_pkg::BYTE_W-1:0] usb_data_i,
   input  logic                         usb_rd_n_i,
   input  logic                         usb_wr_n_i,
   input  logic                         usb_ce_n_i,
   input  logic                         usb_ale_n_i,
   input  husky_pkg::rdata_vec_t        src_rdata_i,
   output logic [husky_pkg::BYTE_W-1:0] usb_data_o,
   output logic                         usb_data_oe_o,
   output husky_pkg::reg_bus_t          bus_o
);
   import husky_pkg::*;

   logic [ADDR_W-1:0] addr_s;       // sampled USB address
   logic [BYTE_W-1:0] data_s;       // sampled USB data
   logic              rd_n_s;
   logic              wr_n_s;
   logic              ce_n_s;
   logic              ale_n_s;
   logic              wr_act;
   logic              rd_act;
   logic              wr_act_q;     // previous sampled write state
   logic              rd_act_q;
   logic [ADDR_W-1:0] addr_q;
   logic [BYTE_W-1:0] wdata_q;
   logic              wr_q;
   logic              rd_q;
   logic [BYTE_W-1:0] rdata_or;
   logic [BYTE_W-1:0] rdata_q;      // merged read data, one cycle behind

   // one input register stage for everything from the USB controller
   always_ff @(posedge clk_usb_buf or negedge rst_n_i) begin
      if (!rst_n_i) begin
         rd_n_s  <= 1'b1;
         wr_n_s  <= 1'b1;
         ce_n_s  <= 1'b1;
         ale_n_s <= 1'b1;
      end else begin
         rd_n_s  <= usb_rd_n_i;
         wr_n_s  <= usb_wr_n_i;
         ce_n_s  <= usb_ce_n_i;
         ale_n_s <= usb_ale_n_i;
      end
   end

   always_ff @(posedge clk_usb_buf) begin
      addr_s <= usb_addr_i;
      data_s <= usb_data_i;
   end

   assign wr_act = ~ce_n_s & ~wr_n_s;
   assign rd_act = ~ce_n_s & ~rd_n_s;

   // falling-edge detect, pulses come one cycle after first low sample
   always_ff @(posedge clk_usb_buf or negedge rst_n_i) begin
      if (!rst_n_i) begin
         wr_act_q <= 1'b0;
         rd_act_q <= 1'b0;
         wr_q     <= 1'b0;
         rd_q     <= 1'b0;
      end else begin
         wr_act_q <= wr_act;
         rd_act_q <= rd_act;
         wr_q     <= wr_act & ~wr_act_q;
         rd_q     <= rd_act & ~rd_act_q;
      end
   end

   always_ff @(posedge clk_usb_buf) begin
      if (!ale_n_s)
         addr_q <= addr_s;          // address phase
      if (wr_act && !wr_act_q)
         wdata_q <= data_s;
   end

   // every block returns zero unless addressed
   always_comb begin
      rdata_or = '0;
      for (int i = 0; i < NUM_RD_SRC; i++)
         rdata_or = rdata_or | src_rdata_i[i];
   end

   always_ff @(posedge clk_usb_buf) begin
      rdata_q <= rdata_or;
      if (rd_q)
         usb_data_o <= rdata_q;     // held for the rest of the strobe
   end

   assign usb_data_oe_o = rd_act;

   assign bus_o.addr  = addr_q;
   assign bus_o.wdata = wdata_q;
   assign bus_o.rd    = rd_q;
   assign bus_o.wr    = wr_q;

endmodule

//--- verif/tb_husky_tasks.svh
task automatic apply_reset();
   rst_n_i = 1'b0;
   repeat (5) @(negedge clk_usb_buf);
   rst_n_i = 1'b1;
   @(negedge clk_usb_buf);
endtask

task automatic finish_test(input string name, input int err_before);
   tests_run++;
   if (errors != err_before) begin
      tests_failed++;
      $display("%s: FAILED (%0d mismatches)", name, errors - err_before);
   end else begin
      $display("%s: ok", name);
   end
endtask

// address phase and the ALE gap the host must keep before a strobe
task automatic set_addr(input logic [7:0] addr);
   usb_addr_i  = addr;
   usb_ale_n_i = 1'b0;
   @(negedge clk_usb_buf);
   usb_ale_n_i = 1'b1;
   repeat (2) @(negedge clk_usb_buf);
endtask

task automatic bus_write(input logic [7:0] addr, input logic [7:0] data);
   set_addr(addr);
   usb_data_i = data;
   usb_ce_n_i = 1'b0;
   usb_wr_n_i = 1'b0;
   repeat (3) @(negedge clk_usb_buf);   // register updated 2 cycles after sampling
   usb_ce_n_i = 1'b1;
   usb_wr_n_i = 1'b1;
   repeat (2) @(negedge clk_usb_buf);
endtask

task automatic bus_read(input logic [7:0] addr, output logic [7:0] data);
   set_addr(addr);
   usb_ce_n_i = 1'b0;
   usb_rd_n_i = 1'b0;
   repeat (3) @(negedge clk_usb_buf);   // data valid 2 cycles after sampling
   if (usb_data_oe_o !== 1'b1) begin
      $display("CHECK FAILED usb_data_oe_o (read of 0x%02h): got 0x%0h expected 0x1",
               addr, usb_data_oe_o);
      errors++;
   end
   data       = usb_data_o;
   usb_ce_n_i = 1'b1;
   usb_rd_n_i = 1'b1;
   repeat (2) @(negedge clk_usb_buf);
endtask

// one cycle of sample strobes on both capture sources
task automatic drive_samples(input logic t_wr, input logic [7:0] t_data,
                             input logic l_wr, input logic [7:0] l_data);
   trace_src_i.wr   = t_wr;
   trace_src_i.data = t_data;
   la_src_i.wr      = l_wr;
   la_src_i.data    = l_data;
   @(negedge clk_usb_buf);
   trace_src_i.wr = 1'b0;
   la_src_i.wr    = 1'b0;
endtask

task automatic reg_access_test();
   logic [7:0] got;
   int         err_before;
   err_before = errors;
   bus_write(TARGET_CTRL_ADDR, 8'h3C);   // power on with nrst and pdid driven high
   bus_read(TARGET_CTRL_ADDR, got);
   if (got !== 8'h3C) begin
      $display("CHECK FAILED TARGET_CTRL: got 0x%02h expected 0x%02h", got, 8'h3C);
      errors++;
   end
   bus_read(8'h55, got);                 // unmapped
   if (got !== 8'h00) begin
      $display("CHECK FAILED usb_data_o (addr 0x55): got 0x%02h expected 0x00", got);
      errors++;
   end
   finish_test("reg_access", err_before);
endtask

task automatic pin_priority_test();
   target_pins_t exp;
   int           err_before;
   err_before = errors;
   apply_reset();
   if (pins_o !== 8'h00 || target_power_on_o !== 1'b0) begin
      $display("CHECK FAILED pins_o/target_power_on_o after reset: got 0x%02h/0x%0h",
               pins_o, target_power_on_o);
      errors++;
   end
   bus_write(TARGET_CTRL_ADDR, 8'h0C);   // nrst_oe, nrst_val high
   exp          = '0;
   exp.nrst_oe  = 1'b1;
   exp.nrst_val = 1'b1;
   if (pins_o !== exp || target_power_on_o !== 1'b1) begin
      $display("CHECK FAILED pins_o (nrst high): got 0x%02h expected 0x%02h", pins_o, exp);
      errors++;
   end
   bus_write(TARGET_CTRL_ADDR, 8'h04);
   exp.nrst_val = 1'b0;
   if (pins_o !== exp) begin
      $display("CHECK FAILED pins_o (nrst low): got 0x%02h expected 0x%02h", pins_o, exp);
      errors++;
   end
   avr_nrst_i    = 1'b1;
   sam_mosi_i    = 1'b0;
   sam_spck_i    = 1'b1;
   target_miso_i = 1'b1;
   bus_write(TARGET_CTRL_ADDR, 8'h02);   // AVR programming
   exp          = '0;
   exp.nrst_oe  = 1'b1;
   exp.nrst_val = 1'b1;
   exp.mosi_oe  = 1'b1;
   exp.sck_oe   = 1'b1;
   exp.sck_val  = 1'b1;
   if (pins_o !== exp || sam_miso_o !== 1'b1 || sam_miso_oe_o !== 1'b1) begin
      $display("CHECK FAILED pins_o/sam_miso_o (avrprog): got 0x%02h/0x%0h expected 0x%02h/0x1",
               pins_o, sam_miso_o, exp);
      errors++;
   end
   avr_nrst_i    = 1'b0;                 // flip every pass-through input
   sam_mosi_i    = 1'b1;
   sam_spck_i    = 1'b0;
   target_miso_i = 1'b0;
   @(negedge clk_usb_buf);
   exp.nrst_val = 1'b0;
   exp.mosi_val = 1'b1;
   exp.sck_val  = 1'b0;
   if (pins_o !== exp || sam_miso_o !== 1'b0) begin
      $display("CHECK FAILED pins_o/sam_miso_o (avrprog flip): got 0x%02h/0x%0h expected 0x%02h/0x0",
               pins_o, sam_miso_o, exp);
      errors++;
   end
   bus_write(TARGET_CTRL_ADDR, 8'h03);   // power off again
   if (pins_o !== 8'h00 || sam_miso_oe_o !== 1'b0 || target_power_on_o !== 1'b0) begin
      $display("CHECK FAILED pins_o/sam_miso_oe_o (power off): got 0x%02h/0x%0h expected 0x00/0x0",
               pins_o, sam_miso_oe_o);
      errors++;
   end
   finish_test("pin_priority", err_before);
endtask

task automatic fifo_order_test();
   logic [7:0] exp_q[$];
   logic [7:0] data;
   logic [7:0] exp;
   logic [7:0] got;
   int         err_before;
   err_before = errors;
   for (int i = 0; i < 5; i++) begin
      data = 8'($random(seed));
      exp_q.push_back(data);
      drive_samples(1'b1, data, 1'b0, 8'h00);
   end
   bus_read(FIFO_STATUS_ADDR, got);
   if (got !== 8'h05) begin
      $display("CHECK FAILED FIFO_STATUS: got 0x%02h expected 0x05", got);
      errors++;
   end
   bus_write(FIFO_CTRL_ADDR, 8'h00);
   for (int i = 0; i < 5; i++) begin
      bus_read(FIFO_DATA_ADDR, got);
      exp = exp_q.pop_front();
      if (got !== exp) begin
         $display("CHECK FAILED FIFO_DATA (trace %0d): got 0x%02h expected 0x%02h", i, got, exp);
         errors++;
      end
   end
   bus_write(FIFO_CTRL_ADDR, 8'h01);     // select LA
   for (int i = 0; i < 3; i++) begin
      data = 8'($random(seed));
      exp_q.push_back(data);
      drive_samples(1'b1, ~data, 1'b1, data);
   end
   for (int i = 0; i < 3; i++) begin
      bus_read(FIFO_DATA_ADDR, got);
      exp = exp_q.pop_front();
      if (got !== exp) begin
         $display("CHECK FAILED FIFO_DATA (LA %0d): got 0x%02h expected 0x%02h", i, got, exp);
         errors++;
      end
   end
   bus_write(FIFO_CTRL_ADDR, 8'h00);     // back to trace
   finish_test("fifo_order", err_before);
endtask

task automatic flush_test();
   logic [7:0] got;
   int         err_before;
   err_before = errors;
   for (int i = 0; i < 3; i++)
      drive_samples(1'b1, 8'hA0 + 8'(i), 1'b0, 8'h00);
   bus_write(FIFO_CTRL_ADDR, 8'h02);     // flush with trace still selected
   bus_read(FIFO_STATUS_ADDR, got);
   if (got !== 8'h80) begin
      $display("CHECK FAILED FIFO_STATUS after flush: got 0x%02h expected 0x80", got);
      errors++;
   end
   finish_test("flush", err_before);
endtask

task automatic errors_leds_test();
   logic [7:0] got;
   logic       seen_lo;
   logic       seen_hi;
   logic       seen_fifo_lo;
   logic       seen_fifo_hi;
   int         err_before;
   err_before   = errors;
   pll_status_i = 1'b1;
   @(negedge clk_usb_buf);
   if (led_adc_o !== 1'b0) begin
      $display("CHECK FAILED led_adc_o (pll locked): got 0x%0h expected 0x0", led_adc_o);
      errors++;
   end
   if (led_fifo_o !== 1'b0) begin
      $display("CHECK FAILED led_fifo_o (fifo empty): got 0x%0h expected 0x0", led_fifo_o);
      errors++;
   end
   pll_status_i = 1'b0;
   @(negedge clk_usb_buf);
   if (led_adc_o !== 1'b1) begin
      $display("CHECK FAILED led_adc_o (pll unlocked): got 0x%0h expected 0x1", led_adc_o);
      errors++;
   end
   bus_read(FIFO_DATA_ADDR, got);        // pop while empty
   if (got !== 8'h00) begin
      $display("CHECK FAILED FIFO_DATA (empty pop): got 0x%02h expected 0x00", got);
      errors++;
   end
   bus_read(STATUS_ADDR, got);
   if (got[ERR_UNDERFLOW_BIT] !== 1'b1) begin
      $display("CHECK FAILED STATUS underflow bit: got 0x%02h expected bit %0d set",
               got, ERR_UNDERFLOW_BIT);
      errors++;
   end
   seen_lo      = 1'b0;
   seen_hi      = 1'b0;
   seen_fifo_lo = 1'b0;
   seen_fifo_hi = 1'b0;
   repeat (64) begin
      @(negedge clk_usb_buf);
      if (led_adc_o === 1'b0)
         seen_lo = 1'b1;
      if (led_adc_o === 1'b1)
         seen_hi = 1'b1;
      if (led_fifo_o === 1'b0)
         seen_fifo_lo = 1'b1;
      if (led_fifo_o === 1'b1)
         seen_fifo_hi = 1'b1;
   end
   if (!(seen_lo && seen_hi)) begin
      $display("led_adc_o did not flash within 64 cycles of the underflow error");
      errors++;
   end
   if (!(seen_fifo_lo && seen_fifo_hi)) begin
      $display("led_fifo_o did not flash within 64 cycles of the underflow error");
      errors++;
   end
   bus_write(STATUS_ADDR, 8'h03);        // write 1s to clear
   bus_read(STATUS_ADDR, got);
   if (got[1:0] !== 2'b00) begin
      $display("CHECK FAILED STATUS flags after clear: got 0x%02h expected flags 0x0", got);
      errors++;
   end
   drive_samples(1'b1, 8'($random(seed)), 1'b0, 8'h00);
   if (led_fifo_o !== 1'b1) begin
      $display("CHECK FAILED led_fifo_o (fifo not empty): got 0x%0h expected 0x1", led_fifo_o);
      errors++;
   end
   for (int i = 0; i < FIFO_DEPTH; i++)  // one past full in total
      drive_samples(1'b1, 8'($random(seed)), 1'b0, 8'h00);
   bus_read(STATUS_ADDR, got);
   if (got[ERR_OVERFLOW_BIT] !== 1'b1) begin
      $display("CHECK FAILED STATUS overflow bit: got 0x%02h expected bit %0d set",
               got, ERR_OVERFLOW_BIT);
      errors++;
   end
   finish_test("errors_leds", err_before);
endtask

//--- verif/tb_husky_top.sv
`timescale 1ns/1ps

module tb_husky_top;
   import husky_pkg::*;

   localparam int FIFO_DEPTH     = 16;
   localparam int FLASH_BITS     = 4;
   localparam int TIMEOUT_CYCLES = 4000;   // ~60 accesses of ~12 cycles plus LED watch

   logic               clk_usb_buf;
   logic               rst_n_i;
   logic [ADDR_W-1:0]  usb_addr_i;
   logic [BYTE_W-1:0]  usb_data_i;
   logic               usb_rd_n_i;
   logic               usb_wr_n_i;
   logic               usb_ce_n_i;
   logic               usb_ale_n_i;
   logic [BYTE_W-1:0]  usb_data_o;
   logic               usb_data_oe_o;
   logic               pll_status_i;
   logic               led_adc_o;
   logic               led_fifo_o;
   logic               sam_mosi_i;
   logic               sam_spck_i;
   logic               avr_nrst_i;
   logic               target_miso_i;
   target_pins_t       pins_o;
   logic               target_power_on_o;
   logic               sam_miso_o;
   logic               sam_miso_oe_o;
   sample_src_t        trace_src_i;
   sample_src_t        la_src_i;

   integer seed;
   int     errors;
   int     tests_run;
   int     tests_failed;
   int     cycle_cnt;

   husky_top #(
      .pFIFO_DEPTH (FIFO_DEPTH),
      .pFLASH_BITS (FLASH_BITS)
   ) husky_top_inst (
      .clk_usb_buf       (clk_usb_buf),
      .rst_n_i           (rst_n_i),
      .usb_addr_i        (usb_addr_i),
      .usb_data_i        (usb_data_i),
      .usb_rd_n_i        (usb_rd_n_i),
      .usb_wr_n_i        (usb_wr_n_i),
      .usb_ce_n_i        (usb_ce_n_i),
      .usb_ale_n_i       (usb_ale_n_i),
      .usb_data_o        (usb_data_o),
      .usb_data_oe_o     (usb_data_oe_o),
      .pll_status_i      (pll_status_i),
      .led_adc_o         (led_adc_o),
      .led_fifo_o        (led_fifo_o),
      .sam_mosi_i        (sam_mosi_i),
      .sam_spck_i        (sam_spck_i),
      .avr_nrst_i        (avr_nrst_i),
      .target_miso_i     (target_miso_i),
      .pins_o            (pins_o),
      .target_power_on_o (target_power_on_o),
      .sam_miso_o        (sam_miso_o),
      .sam_miso_oe_o     (sam_miso_oe_o),
      .trace_src_i       (trace_src_i),
      .la_src_i          (la_src_i)
   );

   `include "tb_husky_tasks.svh"

   initial begin
      clk_usb_buf = 1'b0;
      forever #2 clk_usb_buf = ~clk_usb_buf;   // 4 ns period
   end

   initial begin
      cycle_cnt = 0;
   end

   always @(posedge clk_usb_buf) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= TIMEOUT_CYCLES) begin
         $display("Timeout: the run went past %0d cycles", TIMEOUT_CYCLES);
         $display("Errors found");
         $finish;
      end
   end

   initial begin
      seed          = 43;
      errors        = 0;
      tests_run     = 0;
      tests_failed  = 0;
      rst_n_i       = 1'b0;
      usb_addr_i    = '0;
      usb_data_i    = '0;
      usb_rd_n_i    = 1'b1;
      usb_wr_n_i    = 1'b1;
      usb_ce_n_i    = 1'b1;
      usb_ale_n_i   = 1'b1;
      pll_status_i  = 1'b1;
      sam_mosi_i    = 1'b0;
      sam_spck_i    = 1'b0;
      avr_nrst_i    = 1'b0;
      target_miso_i = 1'b0;
      trace_src_i   = '0;
      la_src_i      = '0;

      apply_reset();
      reg_access_test();
      pin_priority_test();
      fifo_order_test();
      flush_test();
      errors_leds_test();

      $display("tests run: %0d, tests failed: %0d, errors: %0d",
               tests_run, tests_failed, errors);
      if (errors == 0) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
      $finish;
   end

endmodule
